// File: logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

   // ----------------------------------------
   // sizes and privilege codes
   // ----------------------------------------
   localparam int XLEN = 32;

   localparam logic [1:0] M_MODE = 2'd3;
   localparam logic [1:0] S_MODE = 2'd1;
   localparam logic [1:0] U_MODE = 2'd0;

   // ----------------------------------------
   // csr addresses
   // ----------------------------------------
   // machine trap setup and handling
   localparam logic [11:0] CSR_MSTATUS       = 12'h300;
   localparam logic [11:0] CSR_MISA          = 12'h301;
   localparam logic [11:0] CSR_MIE           = 12'h304;
   localparam logic [11:0] CSR_MTVEC         = 12'h305;
   localparam logic [11:0] CSR_MCOUNTEREN    = 12'h306;
   localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;
   localparam logic [11:0] CSR_MSCRATCH      = 12'h340;
   localparam logic [11:0] CSR_MEPC          = 12'h341;
   localparam logic [11:0] CSR_MCAUSE        = 12'h342;
   localparam logic [11:0] CSR_MTVAL         = 12'h343;
   // the two supervisor registers kept
   localparam logic [11:0] CSR_SCOUNTEREN    = 12'h106;
   localparam logic [11:0] CSR_SSCRATCH      = 12'h140;
   // machine counters, writable
   localparam logic [11:0] CSR_MCYCLE        = 12'hB00;
   localparam logic [11:0] CSR_MINSTRET      = 12'hB02;
   localparam logic [11:0] CSR_MCYCLEH       = 12'hB80;
   localparam logic [11:0] CSR_MINSTRETH     = 12'hB82;
   // read-only shadows, gated by counteren
   localparam logic [11:0] CSR_CYCLE         = 12'hC00;
   localparam logic [11:0] CSR_TIME          = 12'hC01;
   localparam logic [11:0] CSR_INSTRET       = 12'hC02;
   localparam logic [11:0] CSR_CYCLEH        = 12'hC80;
   localparam logic [11:0] CSR_TIMEH         = 12'hC81;
   localparam logic [11:0] CSR_INSTRETH      = 12'hC82;
   // machine information
   localparam logic [11:0] CSR_MVENDORID     = 12'hF11;
   localparam logic [11:0] CSR_MARCHID       = 12'hF12;
   localparam logic [11:0] CSR_MIMPID        = 12'hF13;
   localparam logic [11:0] CSR_MHARTID       = 12'hF14;

   // ----------------------------------------
   // constant values and write masks
   // ----------------------------------------
   // mxl = 1 (rv32), extensions i and m
   localparam logic [XLEN-1:0] MISA_VALUE      = 32'h4000_1100;
   // non-commercial vendor id
   localparam logic [XLEN-1:0] MVENDORID_VALUE = 32'h0000_0000;
   localparam logic [XLEN-1:0] MARCHID_VALUE   = 32'h0000_0019;
   localparam logic [XLEN-1:0] MIMPID_VALUE    = 32'h0000_0100;
   localparam logic [XLEN-1:0] MHARTID_VALUE   = 32'h0000_0000;

   // mpp[12:11], mpie 7, spie 5, mie 3, sie 1
   localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_18AA;
   // meie, seie, mtie, stie, msie, ssie
   localparam logic [XLEN-1:0] MIE_WMASK     = 32'h0000_0AAA;
   // mode 2 and 3 are reserved, so bit 1 stays low
   localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hFFFF_FFFD;
   // ialign 32, no compressed instructions
   localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFF_FFFC;

   // mcountinhibit bit positions
   localparam int INH_CY = 0;
   localparam int INH_IR = 2;

   // address seen as a word or as its rw / priv / index fields
   typedef union packed {
      logic [11:0] raw;
      struct packed {
         logic [1:0] rw;
         logic [1:0] priv;
         logic [7:0] index;
      } f;
   } csr_addr_t;

endpackage

`default_nettype wire

// File: logic/csr_state_if.sv
`default_nettype none

interface csr_state_if;

   // current value and value after the next edge, per register
   logic [csr_pkg::XLEN-1:0] mstatus, nxt_mstatus;
   logic [csr_pkg::XLEN-1:0] mie, nxt_mie;
   logic [csr_pkg::XLEN-1:0] mtvec, nxt_mtvec;
   logic [csr_pkg::XLEN-1:0] mcounteren, nxt_mcounteren;
   logic [csr_pkg::XLEN-1:0] mcountinhibit, nxt_mcountinhibit;
   logic [csr_pkg::XLEN-1:0] mscratch, nxt_mscratch;
   logic [csr_pkg::XLEN-1:0] mepc, nxt_mepc;
   logic [csr_pkg::XLEN-1:0] mcause, nxt_mcause;
   logic [csr_pkg::XLEN-1:0] mtval, nxt_mtval;
   logic [csr_pkg::XLEN-1:0] scounteren, nxt_scounteren;
   logic [csr_pkg::XLEN-1:0] sscratch, nxt_sscratch;

   // full 64-bit counters
   logic [2*csr_pkg::XLEN-1:0] mcycle, nxt_mcycle;
   logic [2*csr_pkg::XLEN-1:0] minstret, nxt_minstret;

   // register file side
   modport regs (
      output mstatus, nxt_mstatus, mie, nxt_mie, mtvec, nxt_mtvec,
      output mcounteren, nxt_mcounteren, mcountinhibit, nxt_mcountinhibit,
      output mscratch, nxt_mscratch, mepc, nxt_mepc, mcause, nxt_mcause,
      output mtval, nxt_mtval, scounteren, nxt_scounteren, sscratch, nxt_sscratch
   );

   // counter side, needs the inhibit bits
   modport cntr (
      output mcycle, nxt_mcycle, minstret, nxt_minstret,
      input  mcountinhibit
   );

   // read selector sees everything
   modport sel (
      input mstatus, nxt_mstatus, mie, nxt_mie, mtvec, nxt_mtvec,
      input mcounteren, nxt_mcounteren, mcountinhibit, nxt_mcountinhibit,
      input mscratch, nxt_mscratch, mepc, nxt_mepc, mcause, nxt_mcause,
      input mtval, nxt_mtval, scounteren, nxt_scounteren, sscratch, nxt_sscratch,
      input mcycle, nxt_mcycle, minstret, nxt_minstret
   );

endinterface

`default_nettype wire

// File: logic/csr_counters.sv
`default_nettype none

module csr_counters
(
   input  logic                     clk_in,
   input  logic                     rst,
   input  logic                     instr_retired,
   input  logic                     csr_wr,
   input  csr_pkg::csr_addr_t       csr_wr_addr,
   input  logic [csr_pkg::XLEN-1:0] csr_wr_data,
   csr_state_if.cntr                st
);

   logic wr_cyc_lo;
   logic wr_cyc_hi;
   logic wr_ins_lo;
   logic wr_ins_hi;

   // ----------------------------------------
   // write decode, one half at a time
   // ----------------------------------------
   assign wr_cyc_lo = csr_wr && (csr_wr_addr.raw == csr_pkg::CSR_MCYCLE);
   assign wr_cyc_hi = csr_wr && (csr_wr_addr.raw == csr_pkg::CSR_MCYCLEH);
   assign wr_ins_lo = csr_wr && (csr_wr_addr.raw == csr_pkg::CSR_MINSTRET);
   assign wr_ins_hi = csr_wr && (csr_wr_addr.raw == csr_pkg::CSR_MINSTRETH);

   // ----------------------------------------
   // next values
   // ----------------------------------------
   always_comb
   begin
      // write wins over the increment
      st.nxt_mcycle = st.mcycle;
      if (wr_cyc_lo)
         st.nxt_mcycle[csr_pkg::XLEN-1:0] = csr_wr_data;
      else if (wr_cyc_hi)
         st.nxt_mcycle[2*csr_pkg::XLEN-1:csr_pkg::XLEN] = csr_wr_data;
      else if (!st.mcountinhibit[csr_pkg::INH_CY])
         st.nxt_mcycle = st.mcycle + 64'd1;

      // counts retire pulses only
      st.nxt_minstret = st.minstret;
      if (wr_ins_lo)
         st.nxt_minstret[csr_pkg::XLEN-1:0] = csr_wr_data;
      else if (wr_ins_hi)
         st.nxt_minstret[2*csr_pkg::XLEN-1:csr_pkg::XLEN] = csr_wr_data;
      else if (instr_retired && !st.mcountinhibit[csr_pkg::INH_IR])
         st.nxt_minstret = st.minstret + 64'd1;
   end

   always_ff @(posedge clk_in)
   begin
      if (rst)
      begin
         st.mcycle   <= '0;
         st.minstret <= '0;
      end
      else
      begin
         st.mcycle   <= st.nxt_mcycle;
         st.minstret <= st.nxt_minstret;
      end
   end

   // inhibit set by the register file freezes the cycle count
   a_cycle_hold: assert property (@(posedge clk_in) disable iff (rst)
      (st.mcountinhibit[csr_pkg::INH_CY] && !wr_cyc_lo && !wr_cyc_hi)
      |=> (st.mcycle == $past(st.mcycle)));

endmodule

`default_nettype wire

// File: logic/csr_machine_regs.sv
`default_nettype none

module csr_machine_regs
(
   input  logic                     clk_in,
   input  logic                     rst,
   input  logic                     csr_wr,
   input  csr_pkg::csr_addr_t       csr_wr_addr,
   input  logic [csr_pkg::XLEN-1:0] csr_wr_data,
   csr_state_if.regs                st
);

   logic wr_en;

   // addresses with rw = 3 are read-only, drop the write
   assign wr_en = csr_wr && (csr_wr_addr.f.rw != 2'b11);

   // ----------------------------------------
   // next values, masked on write
   // ----------------------------------------
   always_comb
   begin
      // hold by default
      st.nxt_mstatus       = st.mstatus;
      st.nxt_mie           = st.mie;
      st.nxt_mtvec         = st.mtvec;
      st.nxt_mcounteren    = st.mcounteren;
      st.nxt_mcountinhibit = st.mcountinhibit;
      st.nxt_mscratch      = st.mscratch;
      st.nxt_mepc          = st.mepc;
      st.nxt_mcause        = st.mcause;
      st.nxt_mtval         = st.mtval;
      st.nxt_scounteren    = st.scounteren;
      st.nxt_sscratch      = st.sscratch;

      if (wr_en)
      begin
         case (csr_wr_addr.raw)
            // bits outside the mask read back as zero
            csr_pkg::CSR_MSTATUS: st.nxt_mstatus = csr_wr_data & csr_pkg::MSTATUS_WMASK;
            csr_pkg::CSR_MIE: st.nxt_mie = csr_wr_data & csr_pkg::MIE_WMASK;
            csr_pkg::CSR_MTVEC: st.nxt_mtvec = csr_wr_data & csr_pkg::MTVEC_WMASK;
            csr_pkg::CSR_MEPC: st.nxt_mepc = csr_wr_data & csr_pkg::MEPC_WMASK;
            // full width registers
            csr_pkg::CSR_MCOUNTEREN: st.nxt_mcounteren = csr_wr_data;
            csr_pkg::CSR_MCOUNTINHIBIT: st.nxt_mcountinhibit = csr_wr_data;
            csr_pkg::CSR_MSCRATCH: st.nxt_mscratch = csr_wr_data;
            csr_pkg::CSR_MCAUSE: st.nxt_mcause = csr_wr_data;
            csr_pkg::CSR_MTVAL: st.nxt_mtval = csr_wr_data;
            csr_pkg::CSR_SCOUNTEREN: st.nxt_scounteren = csr_wr_data;
            csr_pkg::CSR_SSCRATCH: st.nxt_sscratch = csr_wr_data;
            // unknown address, nothing changes
            default: ;
         endcase
      end
   end

   // ----------------------------------------
   // register stage
   // ----------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst)
      begin
         st.mstatus       <= '0;
         st.mie           <= '0;
         st.mtvec         <= '0;
         st.mcounteren    <= '0;
         st.mcountinhibit <= '0;
         st.mscratch      <= '0;
         st.mepc          <= '0;
         st.mcause        <= '0;
         st.mtval         <= '0;
         st.scounteren    <= '0;
         st.sscratch      <= '0;
      end
      else
      begin
         st.mstatus       <= st.nxt_mstatus;
         st.mie           <= st.nxt_mie;
         st.mtvec         <= st.nxt_mtvec;
         st.mcounteren    <= st.nxt_mcounteren;
         st.mcountinhibit <= st.nxt_mcountinhibit;
         st.mscratch      <= st.nxt_mscratch;
         st.mepc          <= st.nxt_mepc;
         st.mcause        <= st.nxt_mcause;
         st.mtval         <= st.nxt_mtval;
         st.scounteren    <= st.nxt_scounteren;
         st.sscratch      <= st.nxt_sscratch;
      end
   end

   // mtvec mode is direct or vectored only
   a_mtvec_mode: assert property (@(posedge clk_in) disable iff (rst)
      !st.mtvec[1]);

endmodule

`default_nettype wire

// File: logic/csr_sel_rdata.sv
`default_nettype none

module csr_sel_rdata
(
   input  logic [1:0]               mode,
   input  logic [63:0]              mtime,
   input  csr_pkg::csr_addr_t       csr_rd_addr,
   csr_state_if.sel                 st,
   output logic                     csr_rd_avail,
   output logic [csr_pkg::XLEN-1:0] csr_rd_data,
   output logic [csr_pkg::XLEN-1:0] csr_fwd_data
);

   logic                     cnt_en;
   logic                     user_cntr;
   logic                     hit;
   logic [csr_pkg::XLEN-1:0] cur;
   logic [csr_pkg::XLEN-1:0] nxt;

   // ----------------------------------------
   // counter availability by mode
   // ----------------------------------------
   always_comb
   begin
      // low 5 bits of the index pick the counteren bit
      case (mode)
         csr_pkg::M_MODE: cnt_en = 1'b1;
         csr_pkg::S_MODE: cnt_en = st.mcounteren[csr_rd_addr.f.index[4:0]];
         csr_pkg::U_MODE: cnt_en = st.scounteren[csr_rd_addr.f.index[4:0]];
         default: cnt_en = 1'b0;
      endcase
   end

   // Cxx space, read-only and user level
   assign user_cntr = (csr_rd_addr.f.rw == 2'b11) && (csr_rd_addr.f.priv == 2'b00);

   // ----------------------------------------
   // address decode, current and next value
   // ----------------------------------------
   always_comb
   begin
      hit = 1'b1;
      cur = '0;
      nxt = '0;
      case (csr_rd_addr.raw)
         csr_pkg::CSR_MSTATUS: {cur, nxt} = {st.mstatus, st.nxt_mstatus};
         csr_pkg::CSR_MIE: {cur, nxt} = {st.mie, st.nxt_mie};
         csr_pkg::CSR_MTVEC: {cur, nxt} = {st.mtvec, st.nxt_mtvec};
         csr_pkg::CSR_MCOUNTEREN: {cur, nxt} = {st.mcounteren, st.nxt_mcounteren};
         csr_pkg::CSR_MCOUNTINHIBIT: {cur, nxt} = {st.mcountinhibit, st.nxt_mcountinhibit};
         csr_pkg::CSR_MSCRATCH: {cur, nxt} = {st.mscratch, st.nxt_mscratch};
         csr_pkg::CSR_MEPC: {cur, nxt} = {st.mepc, st.nxt_mepc};
         csr_pkg::CSR_MCAUSE: {cur, nxt} = {st.mcause, st.nxt_mcause};
         csr_pkg::CSR_MTVAL: {cur, nxt} = {st.mtval, st.nxt_mtval};
         csr_pkg::CSR_SCOUNTEREN: {cur, nxt} = {st.scounteren, st.nxt_scounteren};
         csr_pkg::CSR_SSCRATCH: {cur, nxt} = {st.sscratch, st.nxt_sscratch};
         // machine counters
         csr_pkg::CSR_MCYCLE: {cur, nxt} = {st.mcycle[31:0], st.nxt_mcycle[31:0]};
         csr_pkg::CSR_MCYCLEH: {cur, nxt} = {st.mcycle[63:32], st.nxt_mcycle[63:32]};
         csr_pkg::CSR_MINSTRET: {cur, nxt} = {st.minstret[31:0], st.nxt_minstret[31:0]};
         csr_pkg::CSR_MINSTRETH: {cur, nxt} = {st.minstret[63:32], st.nxt_minstret[63:32]};
         // shadows of the same counters
         csr_pkg::CSR_CYCLE: {cur, nxt} = {st.mcycle[31:0], st.nxt_mcycle[31:0]};
         csr_pkg::CSR_CYCLEH: {cur, nxt} = {st.mcycle[63:32], st.nxt_mcycle[63:32]};
         csr_pkg::CSR_INSTRET: {cur, nxt} = {st.minstret[31:0], st.nxt_minstret[31:0]};
         csr_pkg::CSR_INSTRETH: {cur, nxt} = {st.minstret[63:32], st.nxt_minstret[63:32]};
         // timer lives outside, same value on both
         csr_pkg::CSR_TIME: {cur, nxt} = {mtime[31:0], mtime[31:0]};
         csr_pkg::CSR_TIMEH: {cur, nxt} = {mtime[63:32], mtime[63:32]};
         // constants
         csr_pkg::CSR_MISA: {cur, nxt} = {csr_pkg::MISA_VALUE, csr_pkg::MISA_VALUE};
         csr_pkg::CSR_MVENDORID: {cur, nxt} = {csr_pkg::MVENDORID_VALUE, csr_pkg::MVENDORID_VALUE};
         csr_pkg::CSR_MARCHID: {cur, nxt} = {csr_pkg::MARCHID_VALUE, csr_pkg::MARCHID_VALUE};
         csr_pkg::CSR_MIMPID: {cur, nxt} = {csr_pkg::MIMPID_VALUE, csr_pkg::MIMPID_VALUE};
         csr_pkg::CSR_MHARTID: {cur, nxt} = {csr_pkg::MHARTID_VALUE, csr_pkg::MHARTID_VALUE};
         default: hit = 1'b0;
      endcase
      // blocked counters read as zero on both values
      if (user_cntr && !cnt_en)
      begin
         cur = '0;
         nxt = '0;
      end
   end

   // ----------------------------------------
   // availability and outputs
   // ----------------------------------------
   always_comb
   begin
      csr_rd_avail = hit && (!user_cntr || cnt_en);
      csr_rd_data  = cur;
      csr_fwd_data = nxt;
      // no value leaks out of an unknown or blocked address
      a_rd_zero: assert (csr_rd_avail || ((csr_rd_data == '0) && (csr_fwd_data == '0)));
   end

endmodule

`default_nettype wire

// File: logic/csr_unit.sv
`default_nettype none

module csr_unit
(
   input  logic        clk_in,
   input  logic        rst,
   // core state
   input  logic [1:0]  mode,
   input  logic [63:0] mtime,
   input  logic        instr_retired,
   // write port
   input  logic        csr_wr,
   input  logic [11:0] csr_wr_addr,
   input  logic [31:0] csr_wr_data,
   // read port
   input  logic [11:0] csr_rd_addr,
   output logic        csr_rd_avail,
   output logic [31:0] csr_rd_data,
   output logic [31:0] csr_fwd_data
);

   // register values, current and next
   csr_state_if st_if ();

   // ----------------------------------------
   // storage
   // ----------------------------------------
   csr_counters csr_counters_i
   (
      .clk_in        (clk_in),
      .rst           (rst),
      .instr_retired (instr_retired),
      .csr_wr        (csr_wr),
      .csr_wr_addr   (csr_wr_addr),
      .csr_wr_data   (csr_wr_data),
      .st            (st_if)
   );

   csr_machine_regs csr_machine_regs_i
   (
      .clk_in      (clk_in),
      .rst         (rst),
      .csr_wr      (csr_wr),
      .csr_wr_addr (csr_wr_addr),
      .csr_wr_data (csr_wr_data),
      .st          (st_if)
   );

   // ----------------------------------------
   // read selection
   // ----------------------------------------
   csr_sel_rdata csr_sel_rdata_i
   (
      .mode         (mode),
      .mtime        (mtime),
      .csr_rd_addr  (csr_rd_addr),
      .st           (st_if),
      .csr_rd_avail (csr_rd_avail),
      .csr_rd_data  (csr_rd_data),
      .csr_fwd_data (csr_fwd_data)
   );

endmodule

`default_nettype wire

// File: verification/csr_unit_tests.svh
// ----------------------------------------
// directed tests, run in order
// ----------------------------------------

// writable mstatus fields: sie 1, mie 3, spie 5, mpie 7, mpp 12:11
localparam logic [31:0] mstatus_bits = (32'h1 << 1) | (32'h1 << 3) | (32'h1 << 5)
                                     | (32'h1 << 7) | (32'h3 << 11);

task automatic expect_read(input string what, input logic [11:0] addr,
                           input logic [31:0] value);
   read_csr(addr);
   check({what, " avail"}, 32'd1, 32'(csr_rd_avail));
   check(what, value, csr_rd_data);
endtask

task automatic test_reset_values();
   logic [11:0] zero_regs [11];
   cur_test = "reset_values";
   expect_read("misa", csr_pkg::CSR_MISA, csr_pkg::MISA_VALUE);
   expect_read("mvendorid", csr_pkg::CSR_MVENDORID, csr_pkg::MVENDORID_VALUE);
   expect_read("marchid", csr_pkg::CSR_MARCHID, csr_pkg::MARCHID_VALUE);
   expect_read("mimpid", csr_pkg::CSR_MIMPID, csr_pkg::MIMPID_VALUE);
   expect_read("mhartid", csr_pkg::CSR_MHARTID, csr_pkg::MHARTID_VALUE);
   zero_regs = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC,
                 csr_pkg::CSR_MCOUNTEREN, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_MSCRATCH,
                 csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL,
                 csr_pkg::CSR_SCOUNTEREN, csr_pkg::CSR_SSCRATCH};
   foreach (zero_regs[i])
      expect_read($sformatf("csr %h", zero_regs[i]), zero_regs[i], 32'h0);
endtask

// first write after reset, so the old value is still 0
task automatic write_and_forward(input string what, input logic [11:0] addr,
                                 input logic [31:0] mask);
   logic [31:0] value;
   rnd = xorshift(rnd);
   value = rnd & mask;
   write_csr(addr, rnd);
   check({what, " fwd"}, value, csr_fwd_data);
   check({what, " old"}, 32'h0, csr_rd_data);
   read_csr(addr);
   check(what, value, csr_rd_data);
endtask

task automatic test_write_forward();
   cur_test = "write_forward";
   write_and_forward("mscratch", csr_pkg::CSR_MSCRATCH, 32'hFFFF_FFFF);
   // mtvec bit 1 and mepc bits 1:0 read as zero
   write_and_forward("mtvec", csr_pkg::CSR_MTVEC, ~32'h2);
   write_and_forward("mepc", csr_pkg::CSR_MEPC, ~32'h3);
   write_and_forward("mstatus", csr_pkg::CSR_MSTATUS, mstatus_bits);
endtask

task automatic test_ignored_writes();
   cur_test = "ignored_writes";
   rnd = xorshift(rnd);
   // F11 has rw = 3, the write is dropped
   write_csr(csr_pkg::CSR_MVENDORID, rnd);
   check("mvendorid fwd", csr_pkg::MVENDORID_VALUE, csr_fwd_data);
   expect_read("mvendorid", csr_pkg::CSR_MVENDORID, csr_pkg::MVENDORID_VALUE);
   read_csr(12'h3A0);
   check("3a0 avail", 32'd0, 32'(csr_rd_avail));
   check("3a0 rd", 32'h0, csr_rd_data);
   check("3a0 fwd", 32'h0, csr_fwd_data);
endtask

task automatic test_counters();
   logic [31:0] n;
   logic [31:0] held_lo;
   logic [31:0] held_hi;
   int          k;
   cur_test = "counters";
   rnd = xorshift(rnd);
   // kept below 2^31 so no carry happens here
   n = rnd & 32'h7FFF_FFFF;
   write_csr(csr_pkg::CSR_MCYCLE, n);
   read_csr(csr_pkg::CSR_MCYCLE);
   cyc_base = {32'h0, n};
   cyc_ref  = cycles;
   for (int i = 0; i < 6; i++)
   begin
      check("mcycle", cycle_word(1'b0), csr_rd_data);
      read_csr(csr_pkg::CSR_MCYCLE);
   end
   rnd = xorshift(rnd);
   k = int'(rnd[2:0]) + 1;
   for (int i = 0; i < k; i++)
   begin
      retire_one(csr_pkg::CSR_MINSTRET);
      read_csr(csr_pkg::CSR_MINSTRET);
   end
   exp_instret = exp_instret + 64'(k);
   check("minstret", exp_instret[31:0], csr_rd_data);

   // cy and ir inhibit, the edge that loads them still counts
   write_csr(csr_pkg::CSR_MCOUNTINHIBIT, 32'h5);
   read_csr(csr_pkg::CSR_MCYCLE);
   held_lo = cycle_word(1'b0);
   held_hi = cycle_word(1'b1);
   check("mcycle at inhibit", held_lo, csr_rd_data);
   for (int i = 0; i < 4; i++)
   begin
      retire_one(csr_pkg::CSR_MCYCLE);
      check("mcycle held", held_lo, csr_rd_data);
      read_csr(csr_pkg::CSR_MINSTRET);
      check("minstret held", exp_instret[31:0], csr_rd_data);
   end

   // all ones in the low half, the next edge carries into the high half
   write_csr(csr_pkg::CSR_MCOUNTINHIBIT, 32'h0);
   write_csr(csr_pkg::CSR_MCYCLE, 32'hFFFF_FFFF);
   read_csr(csr_pkg::CSR_MCYCLEH);
   check("mcycleh before carry", held_hi, csr_rd_data);
   check("mcycleh fwd", held_hi + 32'd1, csr_fwd_data);
   cyc_base = {held_hi, 32'hFFFF_FFFF};
   cyc_ref  = cycles;
   read_csr(csr_pkg::CSR_MCYCLEH);
   check("mcycleh after carry", held_hi + 32'd1, csr_rd_data);
endtask

task automatic test_counter_avail();
   logic [31:0] mcen;
   logic [31:0] scen;
   logic [11:0] shadow [6];
   logic [1:0]  modes [3];
   logic        avail;
   logic        hi;
   logic [31:0] value;
   cur_test = "counter_avail";
   rnd = xorshift(rnd);
   mcen = rnd;
   rnd = xorshift(rnd);
   scen = rnd;
   write_csr(csr_pkg::CSR_MCOUNTEREN, mcen);
   write_csr(csr_pkg::CSR_SCOUNTEREN, scen);
   shadow = '{12'hC00, 12'hC01, 12'hC02, 12'hC80, 12'hC81, 12'hC82};
   modes = '{csr_pkg::M_MODE, csr_pkg::S_MODE, csr_pkg::U_MODE};
   foreach (modes[m])
      foreach (shadow[a])
      begin
         read_csr(shadow[a], modes[m]);
         // M sees every counter, S needs mcounteren, U needs scounteren
         if (modes[m] == csr_pkg::M_MODE)
            avail = 1'b1;
         else if (modes[m] == csr_pkg::S_MODE)
            avail = mcen[shadow[a][4:0]];
         else
            avail = scen[shadow[a][4:0]];
         hi = shadow[a][7];
         case (shadow[a][1:0])
            2'd0: value = cycle_word(hi);
            2'd1: value = hi ? mtime[63:32] : mtime[31:0];
            default: value = hi ? exp_instret[63:32] : exp_instret[31:0];
         endcase
         if (!avail)
            value = 32'h0;
         check($sformatf("avail %h mode %0d", shadow[a], modes[m]),
               32'(avail), 32'(csr_rd_avail));
         check($sformatf("data %h mode %0d", shadow[a], modes[m]), value, csr_rd_data);
      end
endtask

// File: verification/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb;

   timeunit 1ns;
   timeprecision 100ps;

   // the directed sequence needs about 100 cycles, so this leaves a wide margin
   localparam int max_cycles = 2000;

   logic        clk_in = 1'b0;
   logic        rst;
   logic [1:0]  mode;
   logic [63:0] mtime;
   logic        instr_retired;
   logic        csr_wr;
   logic [11:0] csr_wr_addr;
   logic [31:0] csr_wr_data;
   logic [11:0] csr_rd_addr;
   logic        csr_rd_avail;
   logic [31:0] csr_rd_data;
   logic [31:0] csr_fwd_data;

   int          cycles = 0;
   logic [31:0] rnd;
   string       cur_test;

   // expected counter state
   logic [63:0] cyc_base;
   int          cyc_ref;
   logic [63:0] exp_instret;

   csr_unit csr_unit_i (.*);

   always #2 clk_in = ~clk_in;

   // ----------------------------------------
   // cycle count and timeout
   // ----------------------------------------
   always @(posedge clk_in)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout, the tests did not finish within %0d cycles", max_cycles);
         $display(">>> FAIL");
         $fatal(1);
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("Error in %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   // mcycle as it should read now, low or high half
   function automatic logic [31:0] cycle_word(input logic hi);
      logic [63:0] c;
      c = cyc_base + 64'(cycles - cyc_ref);
      return hi ? c[63:32] : c[31:0];
   endfunction

   // ----------------------------------------
   // bus cycles, outputs sampled at the falling edge
   // ----------------------------------------
   task automatic read_csr(input logic [11:0] addr, input logic [1:0] m = csr_pkg::M_MODE);
      @(posedge clk_in);
      csr_wr        <= 1'b0;
      instr_retired <= 1'b0;
      mode          <= m;
      csr_rd_addr   <= addr;
      @(negedge clk_in);
   endtask

   // strobe stays high until the next bus cycle clears it
   task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk_in);
      csr_wr        <= 1'b1;
      csr_wr_addr   <= addr;
      csr_wr_data   <= data;
      instr_retired <= 1'b0;
      mode          <= csr_pkg::M_MODE;
      csr_rd_addr   <= addr;
      @(negedge clk_in);
   endtask

   task automatic retire_one(input logic [11:0] addr);
      @(posedge clk_in);
      csr_wr        <= 1'b0;
      instr_retired <= 1'b1;
      csr_rd_addr   <= addr;
      @(negedge clk_in);
   endtask

`include "csr_unit_tests.svh"

   initial
   begin
      rst           <= 1'b1;
      mode          <= csr_pkg::M_MODE;
      mtime         <= 64'h0;
      instr_retired <= 1'b0;
      csr_wr        <= 1'b0;
      csr_wr_addr   <= 12'h0;
      csr_wr_data   <= 32'h0;
      csr_rd_addr   <= 12'h0;
      rnd           = 32'd65222;
      cyc_base      = 64'h0;
      cyc_ref       = 0;
      exp_instret   = 64'h0;
      cur_test      = "reset";
      repeat (10) @(posedge clk_in);
      rst <= 1'b0;
      // timer stays constant for the whole run
      rnd = xorshift(rnd);
      mtime[63:32] <= rnd;
      rnd = xorshift(rnd);
      mtime[31:0] <= rnd;
      test_reset_values();
      test_write_forward();
      test_ignored_writes();
      test_counters();
      test_counter_avail();
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+verification
logic/csr_pkg.sv
logic/csr_state_if.sv
logic/csr_counters.sv
logic/csr_machine_regs.sv
logic/csr_sel_rdata.sv
logic/csr_unit.sv
verification/csr_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build csr_unit_tb with verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
   --top-module csr_unit_tb -f list.f -o csr_unit_sim &&
./obj_dir/csr_unit_sim | tee /dev/stderr | grep -Fx ">>> PASS" > /dev/null &&
echo "csr_unit simulation passed" ||
{ echo "csr_unit simulation failed"; exit 1; }
